/* vi_pkg.sv */
// Shared widths, opcodes, instruction formats and stage records for the integer core
package vi_pkg;

	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int NUM_REGS    = 32;
	localparam int MULT_STAGES = 5;
	localparam int IMM_W       = 15;
	localparam int OPCODE_W    = 7;
	localparam int PC_W        = 20;

	// Any opcode outside this list decodes as a NOP
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP  = 7'h00,
		OP_ADD  = 7'h01,
		OP_SUB  = 7'h02,
		OP_AND  = 7'h03,
		OP_OR   = 7'h04,
		OP_ADDI = 7'h05,
		OP_MUL  = 7'h06
	} opcode_e;

	typedef struct packed {
		opcode_e                 opcode;
		logic [REG_ADDR_W-1:0]   rd;
		logic [REG_ADDR_W-1:0]   ra;
		logic [REG_ADDR_W-1:0]   rb;
		logic [9:0]              unused;
	} instr_r_t;

	typedef struct packed {
		opcode_e                 opcode;
		logic [REG_ADDR_W-1:0]   rd;
		logic [REG_ADDR_W-1:0]   ra;
		logic signed [IMM_W-1:0] imm;
	} instr_i_t;

	// Same word seen as register or immediate format
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_OR  = 2'd3
	} alu_op_e;

	// Operand source picked in decode, applied at the execute latch input
	typedef enum logic [1:0] {
		BYP_REG = 2'd0,
		BYP_EXE = 2'd1,
		BYP_MUL = 2'd2,
		BYP_WB  = 2'd3
	} byp_sel_e;

	typedef struct packed {
		alu_op_e               alu_op;
		logic                  use_imm;
		logic                  is_mul;
		logic                  wr_en;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] ra;
		logic [REG_ADDR_W-1:0] rb;
		logic [XLEN-1:0]       imm_ext;
	} dec_ctrl_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] addr;
		logic [XLEN-1:0]       data;
	} wb_t;

endpackage

/* vi_fetch.sv */
// Fetch stage holding the word-address PC and the fetch/decode latch that freeze while decode stalls
`timescale 1ns/1ps

module vi_fetch (
	input  logic                      clk_i,
	input  logic                      arst_n_i,
	input  logic                      stall_i,
	input  vi_pkg::instr_u            instr_i,
	output logic [vi_pkg::PC_W-1:0]   pc_o,
	output vi_pkg::instr_u            dec_instr_o
);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= '0;
		end else if (!stall_i) begin
			pc_o <= pc_o + 1'b1;
		end
	end

	// Word returned for pc_o this cycle enters decode on the edge
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dec_instr_o <= '0;
		end else if (!stall_i) begin
			dec_instr_o <= instr_i;
		end
	end

endmodule

/* vi_decoder.sv */
// Instruction decoder that turns the latched word into the control record for decode and execute
`timescale 1ns/1ps

module vi_decoder (
	input  vi_pkg::instr_u    instr_i,
	output vi_pkg::dec_ctrl_t ctrl_o
);

	logic is_r;
	logic writes;

	always_comb begin
		ctrl_o         = '0;
		ctrl_o.alu_op  = vi_pkg::ALU_ADD;
		is_r           = 1'b0;
		writes         = 1'b0;
		ctrl_o.imm_ext = {{(vi_pkg::XLEN-vi_pkg::IMM_W){instr_i.i.imm[vi_pkg::IMM_W-1]}},
			instr_i.i.imm};

		case (instr_i.r.opcode)
			vi_pkg::OP_ADD: begin
				is_r   = 1'b1;
				writes = 1'b1;
			end
			vi_pkg::OP_SUB: begin
				is_r          = 1'b1;
				writes        = 1'b1;
				ctrl_o.alu_op = vi_pkg::ALU_SUB;
			end
			vi_pkg::OP_AND: begin
				is_r          = 1'b1;
				writes        = 1'b1;
				ctrl_o.alu_op = vi_pkg::ALU_AND;
			end
			vi_pkg::OP_OR: begin
				is_r          = 1'b1;
				writes        = 1'b1;
				ctrl_o.alu_op = vi_pkg::ALU_OR;
			end
			vi_pkg::OP_ADDI: begin
				writes         = 1'b1;
				ctrl_o.use_imm = 1'b1;
			end
			vi_pkg::OP_MUL: begin
				is_r          = 1'b1;
				writes        = 1'b1;
				ctrl_o.is_mul = 1'b1;
			end
			default: begin
			end
		endcase

		// Unused source fields stay zero so they never cause a stall
		if (is_r) begin
			ctrl_o.rd = instr_i.r.rd;
			ctrl_o.ra = instr_i.r.ra;
			ctrl_o.rb = instr_i.r.rb;
		end else if (ctrl_o.use_imm) begin
			ctrl_o.rd = instr_i.i.rd;
			ctrl_o.ra = instr_i.i.ra;
		end

		ctrl_o.wr_en = writes && (ctrl_o.rd != '0);
	end

endmodule

/* vi_int_registers.sv */
// Integer register file read by decode and written from the write-back latch
`timescale 1ns/1ps

module vi_int_registers (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] read_addr_a_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] read_addr_b_i,
	input  vi_pkg::wb_t                   wb_i,
	output logic [vi_pkg::XLEN-1:0]       read_data_a_o,
	output logic [vi_pkg::XLEN-1:0]       read_data_b_o
);

	logic [vi_pkg::XLEN-1:0] regs [vi_pkg::NUM_REGS];

	// r0 is never written so it keeps its reset value of zero
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < vi_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.valid && (wb_i.addr != '0)) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	// Same-cycle write is not visible here, decode forwards from write-back instead
	assign read_data_a_o = regs[read_addr_a_i];
	assign read_data_b_o = regs[read_addr_b_i];

endmodule

/* vi_bypass_ctrl.sv */
// Hazard control that picks the forwarding source per operand and stalls decode for pending muls
`timescale 1ns/1ps

module vi_bypass_ctrl (
	input  vi_pkg::dec_ctrl_t                       ctrl_i,
	input  vi_pkg::wb_t                             exe_i,
	input  logic                                    exe_is_mul_i,
	input  vi_pkg::wb_t [vi_pkg::MULT_STAGES-1:0]   mult_stages_i,
	input  vi_pkg::wb_t                             wb_i,
	output vi_pkg::byp_sel_e                        sel_a_o,
	output vi_pkg::byp_sel_e                        sel_b_o,
	output logic                                    stall_o
);

	logic pend_a;
	logic pend_b;
	logic pend_rd;
	logic wb_clash;

	function automatic logic hits(input vi_pkg::wb_t rec,
		input logic [vi_pkg::REG_ADDR_W-1:0] addr);
		return rec.valid && (addr != '0) && (rec.addr == addr);
	endfunction

	// Youngest producer wins in the order execute, last mul stage, write-back
	function automatic vi_pkg::byp_sel_e pick(input logic [vi_pkg::REG_ADDR_W-1:0] addr,
		input vi_pkg::wb_t exe, input logic exe_mul, input vi_pkg::wb_t last,
		input vi_pkg::wb_t wb);
		vi_pkg::byp_sel_e sel;
		sel = vi_pkg::BYP_REG;
		if (hits(exe, addr) && !exe_mul) begin
			sel = vi_pkg::BYP_EXE;
		end else if (hits(last, addr)) begin
			sel = vi_pkg::BYP_MUL;
		end else if (hits(wb, addr)) begin
			sel = vi_pkg::BYP_WB;
		end
		return sel;
	endfunction

	// Muls whose result is not yet available to forward
	always_comb begin
		pend_a  = 1'b0;
		pend_b  = 1'b0;
		pend_rd = 1'b0;
		if (exe_is_mul_i) begin
			pend_a  = hits(exe_i, ctrl_i.ra);
			pend_b  = hits(exe_i, ctrl_i.rb);
			pend_rd = ctrl_i.wr_en && hits(exe_i, ctrl_i.rd);
		end
		for (int s = 0; s < vi_pkg::MULT_STAGES - 1; s++) begin
			pend_a  = pend_a | hits(mult_stages_i[s], ctrl_i.ra);
			pend_b  = pend_b | hits(mult_stages_i[s], ctrl_i.rb);
			pend_rd = pend_rd | (ctrl_i.wr_en && hits(mult_stages_i[s], ctrl_i.rd));
		end
	end

	// A mul one stage short of the end reaches write-back together with this instruction
	assign wb_clash = ctrl_i.wr_en && !ctrl_i.is_mul &&
		mult_stages_i[vi_pkg::MULT_STAGES-2].valid;

	assign stall_o = pend_a || pend_b || pend_rd || wb_clash;

	assign sel_a_o = pick(ctrl_i.ra, exe_i, exe_is_mul_i,
		mult_stages_i[vi_pkg::MULT_STAGES-1], wb_i);
	assign sel_b_o = pick(ctrl_i.rb, exe_i, exe_is_mul_i,
		mult_stages_i[vi_pkg::MULT_STAGES-1], wb_i);

endmodule

/* vi_mult_pipe.sv */
// Multiply unit that forms the product on entry and carries it down a fixed-length delay chain
`timescale 1ns/1ps

module vi_mult_pipe (
	input  logic                                  clk_i,
	input  logic                                  arst_n_i,
	input  logic                                  start_i,
	input  logic [vi_pkg::XLEN-1:0]               a_i,
	input  logic [vi_pkg::XLEN-1:0]               b_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0]         rd_i,
	output vi_pkg::wb_t [vi_pkg::MULT_STAGES-1:0] stages_o
);

	logic [vi_pkg::XLEN-1:0] product;

	// Only the low word is kept
	assign product = a_i * b_i;

	// Each stage holds an independent mul, so several can be in flight
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stages_o <= '0;
		end else begin
			stages_o[0].valid <= start_i;
			stages_o[0].addr  <= rd_i;
			stages_o[0].data  <= product;
			for (int s = 1; s < vi_pkg::MULT_STAGES; s++) begin
				stages_o[s] <= stages_o[s-1];
			end
		end
	end

endmodule

/* vi_execute.sv */
// Execute stage with the decode/execute latch, forwarding, integer ALU and the write-back latch
`timescale 1ns/1ps

module vi_execute (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  logic                    stall_i,
	input  vi_pkg::dec_ctrl_t       ctrl_i,
	input  logic [vi_pkg::XLEN-1:0] reg_a_i,
	input  logic [vi_pkg::XLEN-1:0] reg_b_i,
	input  vi_pkg::byp_sel_e        sel_a_i,
	input  vi_pkg::byp_sel_e        sel_b_i,
	input  vi_pkg::wb_t             mult_last_i,
	output vi_pkg::wb_t             exe_o,
	output logic                    exe_is_mul_o,
	output logic                    mul_start_o,
	output logic [vi_pkg::XLEN-1:0] mul_a_o,
	output logic [vi_pkg::XLEN-1:0] mul_b_o,
	output vi_pkg::wb_t             wb_o
);

	vi_pkg::dec_ctrl_t       ex_ctrl;
	logic [vi_pkg::XLEN-1:0] op_a;
	logic [vi_pkg::XLEN-1:0] op_b;
	logic [vi_pkg::XLEN-1:0] alu_b;
	logic [vi_pkg::XLEN-1:0] alu_res;

	function automatic logic [vi_pkg::XLEN-1:0] fwd(input vi_pkg::byp_sel_e sel,
		input logic [vi_pkg::XLEN-1:0] reg_val, input logic [vi_pkg::XLEN-1:0] exe_val,
		input logic [vi_pkg::XLEN-1:0] mul_val, input logic [vi_pkg::XLEN-1:0] wb_val);
		case (sel)
			vi_pkg::BYP_EXE: return exe_val;
			vi_pkg::BYP_MUL: return mul_val;
			vi_pkg::BYP_WB:  return wb_val;
			default:         return reg_val;
		endcase
	endfunction

	// Stall turns the slot into a bubble
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_ctrl <= '0;
		end else begin
			ex_ctrl <= ctrl_i;
			if (stall_i) begin
				ex_ctrl.wr_en <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		op_a <= fwd(sel_a_i, reg_a_i, alu_res, mult_last_i.data, wb_o.data);
		op_b <= fwd(sel_b_i, reg_b_i, alu_res, mult_last_i.data, wb_o.data);
	end

	assign alu_b = ex_ctrl.use_imm ? ex_ctrl.imm_ext : op_b;

	always_comb begin
		case (ex_ctrl.alu_op)
			vi_pkg::ALU_SUB: alu_res = op_a - alu_b;
			vi_pkg::ALU_AND: alu_res = op_a & alu_b;
			vi_pkg::ALU_OR:  alu_res = op_a | alu_b;
			default:         alu_res = op_a + alu_b;
		endcase
	end

	assign exe_o.valid  = ex_ctrl.wr_en;
	assign exe_o.addr   = ex_ctrl.rd;
	assign exe_o.data   = alu_res;
	assign exe_is_mul_o = ex_ctrl.is_mul;
	assign mul_start_o  = ex_ctrl.wr_en && ex_ctrl.is_mul;
	assign mul_a_o      = op_a;
	assign mul_b_o      = op_b;

	// Decode keeps ALU results away from cycles where the mul chain delivers
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_o <= '0;
		end else if (mult_last_i.valid) begin
			wb_o <= mult_last_i;
		end else begin
			wb_o.valid <= ex_ctrl.wr_en && !ex_ctrl.is_mul;
			wb_o.addr  <= ex_ctrl.rd;
			wb_o.data  <= alu_res;
		end
	end

endmodule

/* vi_core.sv */
// Top level of the integer core; instruction words come in on instr_i for the address on pc_o
`timescale 1ns/1ps

module vi_core (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  vi_pkg::instr_u          instr_i,
	output logic [vi_pkg::PC_W-1:0] pc_o,
	output vi_pkg::wb_t             wb_o
);

	vi_pkg::instr_u                        dec_instr;
	vi_pkg::dec_ctrl_t                     dec_ctrl;
	logic [vi_pkg::XLEN-1:0]               reg_a;
	logic [vi_pkg::XLEN-1:0]               reg_b;
	vi_pkg::byp_sel_e                      sel_a;
	vi_pkg::byp_sel_e                      sel_b;
	logic                                  stall;
	vi_pkg::wb_t                           exe_rec;
	logic                                  exe_is_mul;
	logic                                  mul_start;
	logic [vi_pkg::XLEN-1:0]               mul_a;
	logic [vi_pkg::XLEN-1:0]               mul_b;
	vi_pkg::wb_t [vi_pkg::MULT_STAGES-1:0] mul_stages;

	vi_fetch u_fetch (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.stall_i     (stall),
		.instr_i     (instr_i),
		.pc_o        (pc_o),
		.dec_instr_o (dec_instr)
	);

	vi_decoder u_decoder (
		.instr_i (dec_instr),
		.ctrl_o  (dec_ctrl)
	);

	vi_int_registers u_int_registers (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.read_addr_a_i (dec_ctrl.ra),
		.read_addr_b_i (dec_ctrl.rb),
		.wb_i          (wb_o),
		.read_data_a_o (reg_a),
		.read_data_b_o (reg_b)
	);

	vi_bypass_ctrl u_bypass_ctrl (
		.ctrl_i        (dec_ctrl),
		.exe_i         (exe_rec),
		.exe_is_mul_i  (exe_is_mul),
		.mult_stages_i (mul_stages),
		.wb_i          (wb_o),
		.sel_a_o       (sel_a),
		.sel_b_o       (sel_b),
		.stall_o       (stall)
	);

	vi_execute u_execute (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.stall_i      (stall),
		.ctrl_i       (dec_ctrl),
		.reg_a_i      (reg_a),
		.reg_b_i      (reg_b),
		.sel_a_i      (sel_a),
		.sel_b_i      (sel_b),
		.mult_last_i  (mul_stages[vi_pkg::MULT_STAGES-1]),
		.exe_o        (exe_rec),
		.exe_is_mul_o (exe_is_mul),
		.mul_start_o  (mul_start),
		.mul_a_o      (mul_a),
		.mul_b_o      (mul_b),
		.wb_o         (wb_o)
	);

	vi_mult_pipe u_mult_pipe (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.start_i  (mul_start),
		.a_i      (mul_a),
		.b_i      (mul_b),
		.rd_i     (exe_rec.addr),
		.stages_o (mul_stages)
	);

endmodule

/* vi_core_chk.sv */
// Concurrent checks on vi_core internals, attached to the core with bind during simulation
`timescale 1ns/1ps

module vi_core_chk (
	input logic                    clk_i,
	input logic                    arst_n_i,
	input logic [vi_pkg::PC_W-1:0] pc_i,
	input logic                    stall_i,
	input logic                    wb_valid_i,
	input logic                    exe_valid_i,
	input logic                    exe_is_mul_i,
	input logic                    mul_last_valid_i
);

	// Failure count read back by the testbench
	int fail_cnt = 0;

	// No instruction can have passed execute yet
	wb_quiet_after_reset: assert property (@(posedge clk_i) $rose(arst_n_i) |=> !wb_valid_i)
	else begin
		fail_cnt++;
		$error("write-back valid in the cycle after reset release");
	end

	pc_held_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		stall_i |=> $stable(pc_i))
	else begin
		fail_cnt++;
		$error("pc_o moved after a stall cycle");
	end

	// Both would compete for the write-back latch
	one_wb_source: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(exe_valid_i && !exe_is_mul_i && mul_last_valid_i))
	else begin
		fail_cnt++;
		$error("ALU record and last mul stage valid together");
	end

endmodule

bind vi_core vi_core_chk i_chk (
	.clk_i            (clk_i),
	.arst_n_i         (arst_n_i),
	.pc_i             (pc_o),
	.stall_i          (stall),
	.wb_valid_i       (wb_o.valid),
	.exe_valid_i      (exe_rec.valid),
	.exe_is_mul_i     (exe_is_mul),
	.mul_last_valid_i (mul_stages[vi_pkg::MULT_STAGES-1].valid)
);

/* vi_core_tb.sv */
// Directed testbench for vi_core that serves words for pc_o and checks wb_o against a register model
`timescale 1ns/1ps

module vi_core_tb;

	logic                    clk_i = 1'b0;
	logic                    arst_n_i;
	vi_pkg::instr_u          instr_i;
	logic [vi_pkg::PC_W-1:0] pc_o;
	vi_pkg::wb_t             wb_o;

	vi_pkg::instr_u          imem [64];
	int                      prog_len;
	logic [vi_pkg::XLEN-1:0] model [vi_pkg::NUM_REGS];
	logic [vi_pkg::XLEN-1:0] last_val [vi_pkg::NUM_REGS];
	vi_pkg::wb_t             log_q [$];
	vi_pkg::wb_t             exp_q [$];
	logic [31:0]             seed = 32'h706e;
	int                      errors = 0;
	int                      tests_run = 0;
	int                      tests_failed = 0;

	vi_core i_dut (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.instr_i  (instr_i),
		.pc_o     (pc_o),
		.wb_o     (wb_o)
	);

	always #2 clk_i = ~clk_i;

	// Past the end of the program the memory returns NOP
	function automatic vi_pkg::instr_u fetch_word(input logic [vi_pkg::PC_W-1:0] pc);
		return (pc < prog_len) ? imem[pc] : '0;
	endfunction

	always @(posedge clk_i) begin
		#1;
		instr_i = fetch_word(pc_o);
	end

	// wb_o is settled mid-cycle
	always @(negedge clk_i) begin
		if (arst_n_i && wb_o.valid) begin
			last_val[wb_o.addr] = wb_o.data;
			log_q.push_back(wb_o);
		end
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic vi_pkg::instr_u r_word(input vi_pkg::opcode_e op,
		input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb);
		vi_pkg::instr_u w;
		w = '0;
		w.r.opcode = op;
		w.r.rd = rd;
		w.r.ra = ra;
		w.r.rb = rb;
		return w;
	endfunction

	function automatic vi_pkg::instr_u i_word(input logic [4:0] rd, input logic [4:0] ra,
		input logic [14:0] imm);
		vi_pkg::instr_u w;
		w.i.opcode = vi_pkg::OP_ADDI;
		w.i.rd = rd;
		w.i.ra = ra;
		w.i.imm = imm;
		return w;
	endfunction

	task automatic emit(input vi_pkg::instr_u w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Reference model in program order where r0 reads as zero and is never written
	task automatic run_model();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		vi_pkg::instr_u w;
		foreach (model[r]) begin
			model[r] = '0;
		end
		exp_q.delete();
		for (int k = 0; k < prog_len; k++) begin
			w = imem[k];
			a = model[w.r.ra];
			b = model[w.r.rb];
			case (w.r.opcode)
				vi_pkg::OP_ADD:  res = a + b;
				vi_pkg::OP_SUB:  res = a - b;
				vi_pkg::OP_AND:  res = a & b;
				vi_pkg::OP_OR:   res = a | b;
				vi_pkg::OP_ADDI: res = a + {{17{w.i.imm[14]}}, w.i.imm};
				vi_pkg::OP_MUL:  res = a * b;
				default:         continue;
			endcase
			if (w.r.rd != 0) begin
				model[w.r.rd] = res;
				exp_q.push_back(vi_pkg::wb_t'{1'b1, w.r.rd, res});
			end
		end
	endtask

	task automatic reset_dut();
		@(posedge clk_i);
		#1;
		arst_n_i = 1'b0;
		instr_i = fetch_word('0);
		log_q.delete();
		foreach (last_val[r]) begin
			last_val[r] = '0;
		end
		repeat (2) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;
	endtask

	// Writes to one register must arrive in program order
	task automatic check_order(input string name);
		int j;
		for (int r = 0; r < vi_pkg::NUM_REGS; r++) begin
			j = 0;
			foreach (log_q[k]) begin
				if (log_q[k].addr == r) begin
					while (j < exp_q.size() && exp_q[j].addr != r) begin
						j++;
					end
					if (j < exp_q.size()) begin
						compare(name, exp_q[j].data, log_q[k].data);
					end else begin
						$display("%s: unexpected write to register %0d", name, r);
						errors++;
					end
					j++;
				end
			end
		end
	endtask

	task automatic run_program(input string name);
		int start_err;
		int cycles;
		start_err = errors;
		run_model();
		reset_dut();
		// Fetch starts from word address zero
		compare(name, '0, pc_o);
		cycles = 0;
		while (log_q.size() < exp_q.size() && cycles < 500) begin
			@(posedge clk_i);
			cycles++;
		end
		if (log_q.size() < exp_q.size()) begin
			$display("%s: timeout waiting for writes", name);
			errors++;
		end
		// Drain so that stray late writes land in the log
		repeat (10) @(posedge clk_i);
		compare(name, exp_q.size(), log_q.size());
		foreach (model[r]) begin
			compare(name, model[r], last_val[r]);
		end
		check_order(name);
		tests_run++;
		if (errors == start_err) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - start_err);
		end
	endtask

	task automatic alu_ops();
		prog_len = 0;
		emit(i_word(1, 0, 1234));
		emit(i_word(2, 0, -300));
		emit(i_word(3, 0, 15'h0f55));
		repeat (3) emit(r_word(vi_pkg::OP_NOP, 0, 0, 0));
		emit(r_word(vi_pkg::OP_ADD, 4, 1, 2));
		emit(r_word(vi_pkg::OP_SUB, 5, 1, 2));
		emit(r_word(vi_pkg::OP_AND, 6, 3, 1));
		emit(r_word(vi_pkg::OP_OR, 7, 3, 2));
		emit(i_word(8, 1, -2000));
		run_program("alu_ops");
	endtask

	task automatic bypass_chains();
		prog_len = 0;
		emit(i_word(1, 0, 5));
		emit(i_word(2, 1, 3));
		emit(r_word(vi_pkg::OP_ADD, 3, 2, 1));
		emit(r_word(vi_pkg::OP_SUB, 4, 3, 2));
		emit(r_word(vi_pkg::OP_NOP, 0, 0, 0));
		emit(r_word(vi_pkg::OP_OR, 5, 4, 3));
		emit(r_word(vi_pkg::OP_AND, 6, 5, 5));
		emit(i_word(1, 6, -1));
		emit(r_word(vi_pkg::OP_ADD, 7, 1, 6));
		run_program("bypass_chains");
	endtask

	task automatic mul_hazards();
		prog_len = 0;
		emit(i_word(1, 0, 7));
		emit(i_word(2, 0, -3));
		emit(r_word(vi_pkg::OP_MUL, 3, 1, 2));
		emit(r_word(vi_pkg::OP_ADD, 4, 3, 1));
		emit(r_word(vi_pkg::OP_MUL, 5, 1, 1));
		emit(i_word(6, 0, 9));
		emit(r_word(vi_pkg::OP_MUL, 7, 2, 2));
		emit(i_word(7, 0, 11));
		emit(r_word(vi_pkg::OP_ADD, 8, 7, 5));
		run_program("mul_hazards");
	endtask

	task automatic r0_writes();
		prog_len = 0;
		emit(i_word(0, 0, 55));
		emit(r_word(vi_pkg::OP_ADD, 1, 0, 0));
		emit(i_word(2, 0, -1));
		emit(r_word(vi_pkg::OP_MUL, 0, 2, 2));
		emit(r_word(vi_pkg::OP_SUB, 3, 0, 2));
		emit(i_word(0, 2, 3));
		emit(r_word(vi_pkg::OP_OR, 4, 0, 0));
		run_program("r0_writes");
	endtask

	// First seven slots walk through every opcode and the rest are drawn from the LCG
	task automatic random_program();
		logic [31:0] op;
		logic [4:0]  rd;
		logic [4:0]  ra;
		logic [4:0]  rb;
		prog_len = 0;
		for (int k = 0; k < 40; k++) begin
			op = (k < 7) ? k : (lcg_next() >> 16) % 7;
			rd = lcg_next() >> 29;
			ra = lcg_next() >> 29;
			rb = lcg_next() >> 29;
			if (op == vi_pkg::OP_ADDI) begin
				emit(i_word(rd, ra, lcg_next() >> 17));
			end else begin
				emit(r_word(vi_pkg::opcode_e'(op[6:0]), rd, ra, rb));
			end
		end
		run_program("random_program");
	endtask

	initial begin
		int total;
		arst_n_i = 1'b0;
		instr_i = '0;
		prog_len = 0;
		alu_ops();
		bypass_chains();
		mul_hazards();
		r0_writes();
		random_program();
		total = errors + i_dut.i_chk.fail_cnt;
		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, total);
		if (total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
vi_pkg.sv
vi_fetch.sv
vi_decoder.sv
vi_int_registers.sv
vi_bypass_ctrl.sv
vi_mult_pipe.sv
vi_execute.sv
vi_core.sv
vi_core_chk.sv
vi_core_tb.sv

/* Bender.yml */
package:
  name: vi_core

sources:
  - vi_pkg.sv
  - vi_fetch.sv
  - vi_decoder.sv
  - vi_int_registers.sv
  - vi_bypass_ctrl.sv
  - vi_mult_pipe.sv
  - vi_execute.sv
  - vi_core.sv
  - target: simulation
    files:
      - vi_core_chk.sv
      - vi_core_tb.sv
